// File: rtl/afifo_pkg.sv
`default_nettype none

package afifo_pkg;

  localparam int unsigned DATA_WIDTH_DEF = 8;
  localparam int unsigned FIFO_DEPTH_DEF = 16;  // power of two only

  // widest pointer the gray helpers handle
  localparam int unsigned PTR_MAX_W = 16;

  typedef logic [PTR_MAX_W-1:0] ptr_max_t;

  function automatic ptr_max_t bin_to_gray(input ptr_max_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_max_t gray_to_bin(input ptr_max_t gray);
    ptr_max_t bin;
    bin = gray;
    for (int i = 1; i < PTR_MAX_W; i++) begin
      bin = bin ^ (gray >> i);  // xor of all higher bits
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// File: rtl/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
  parameter int unsigned DATA_WIDTH = 8,
  parameter int unsigned ADDR_WIDTH = 4
) (
  // write side
  input  wire                  wr_clk,
  input  wire                  wr_en,
  input  wire [ADDR_WIDTH-1:0] wr_addr,
  input  wire [DATA_WIDTH-1:0] wr_data,
  // read side
  input  wire                  rd_clk,
  input  wire                  rd_rst_n,
  input  wire                  rd_en,
  input  wire [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  localparam int unsigned DEPTH = 2 ** ADDR_WIDTH;

  typedef logic [DATA_WIDTH-1:0] data_t;

  data_t mem [DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read register holds until next accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/gray_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gray_sync import afifo_pkg::*; #(
  parameter int unsigned PTR_W = 5
) (
  input  wire              dst_clk,
  input  wire              dst_rst_n,
  input  wire [PTR_W-1:0]  ptr_gray,   // from source domain
  output logic [PTR_W-1:0] ptr_bin
);

  typedef logic [PTR_W-1:0] ptr_t;

  ptr_t     sync_q1;
  ptr_t     sync_q2;
  ptr_max_t sync_wide;
  ptr_max_t bin_wide;

  // only one bit moves per source step, so a late sample is just the old value
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= ptr_gray;
      sync_q2 <= sync_q1;
    end
  end

  always_comb begin
    sync_wide = ptr_max_t'(sync_q2);  // zero upper bits
    bin_wide  = gray_to_bin(sync_wide);
    ptr_bin   = ptr_t'(bin_wide);
  end

endmodule

`default_nettype wire

// File: rtl/fifo_wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_wr_ctrl import afifo_pkg::*; #(
  parameter int unsigned ADDR_WIDTH = 4,
  parameter int unsigned FIFO_AFULL = 2 ** ADDR_WIDTH - 2
) (
  input  wire                    wr_clk,
  input  wire                    wr_rst_n,
  input  wire                    wr_en,
  input  wire  [ADDR_WIDTH:0]    rd_ptr_bin_ws,   // read pointer seen in write domain
  output logic                   mem_wr,
  output logic [ADDR_WIDTH-1:0]  mem_wr_addr,
  output logic [ADDR_WIDTH:0]    wr_ptr_gray,
  output logic                   full,
  output logic                   afull
);

  typedef logic [ADDR_WIDTH:0] ptr_t;

  localparam ptr_t DEPTH = {1'b1, {ADDR_WIDTH{1'b0}}};

  ptr_t     wr_ptr;
  ptr_t     wr_ptr_nxt;
  ptr_t     wr_gray_nxt;
  ptr_t     wr_level;
  ptr_max_t wr_ptr_wide;
  logic     full_nxt;
  logic     afull_nxt;

  // accepted write
  assign mem_wr      = wr_en && !full;
  assign mem_wr_addr = wr_ptr[ADDR_WIDTH-1:0];

  always_comb begin
    if (mem_wr) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  always_comb begin
    wr_ptr_wide = ptr_max_t'(wr_ptr_nxt);
    wr_gray_nxt = ptr_t'(bin_to_gray(wr_ptr_wide));
  end

  // level from the stale read pointer, never lower than the true one
  assign wr_level  = wr_ptr_nxt - rd_ptr_bin_ws;
  assign full_nxt  = (wr_level == DEPTH);
  assign afull_nxt = (wr_level >= FIFO_AFULL);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt;  // registered, glitch free into rd domain
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

endmodule

`default_nettype wire

// File: rtl/fifo_rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_rd_ctrl import afifo_pkg::*; #(
  parameter int unsigned ADDR_WIDTH  = 4,
  parameter int unsigned FIFO_AEMPTY = 1
) (
  input  wire                    rd_clk,
  input  wire                    rd_rst_n,
  input  wire                    rd_en,
  input  wire  [ADDR_WIDTH:0]    wr_ptr_bin_rs,   // write pointer seen in read domain
  output logic                   mem_rd,
  output logic [ADDR_WIDTH-1:0]  mem_rd_addr,
  output logic [ADDR_WIDTH:0]    rd_ptr_gray,
  output logic                   empty,
  output logic                   aempty
);

  typedef logic [ADDR_WIDTH:0] ptr_t;

  ptr_t     rd_ptr;
  ptr_t     rd_ptr_nxt;
  ptr_t     rd_gray_nxt;
  ptr_t     rd_level;
  ptr_max_t rd_ptr_wide;
  logic     empty_nxt;
  logic     aempty_nxt;

  // accepted read
  assign mem_rd      = rd_en && !empty;
  assign mem_rd_addr = rd_ptr[ADDR_WIDTH-1:0];

  always_comb begin
    if (mem_rd) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  always_comb begin
    rd_ptr_wide = ptr_max_t'(rd_ptr_nxt);
    rd_gray_nxt = ptr_t'(bin_to_gray(rd_ptr_wide));
  end

  // stale write pointer makes this an underestimate
  assign rd_level   = wr_ptr_bin_rs - rd_ptr_nxt;
  assign empty_nxt  = (wr_ptr_bin_rs == rd_ptr_nxt);
  assign aempty_nxt = (rd_level <= FIFO_AEMPTY);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // flags come out of reset as empty
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

endmodule

`default_nettype wire

// File: rtl/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo import afifo_pkg::*; #(
  parameter int unsigned DATA_WIDTH  = DATA_WIDTH_DEF,
  parameter int unsigned FIFO_DEPTH  = FIFO_DEPTH_DEF,
  parameter int unsigned FIFO_AFULL  = FIFO_DEPTH - 2,
  parameter int unsigned FIFO_AEMPTY = 1
) (
  // write domain
  input  wire                   wr_clk,
  input  wire                   wr_rst_n,
  input  wire                   wr_en,
  input  wire  [DATA_WIDTH-1:0] wr_data,
  // read domain
  input  wire                   rd_clk,
  input  wire                   rd_rst_n,
  input  wire                   rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  afull,
  output logic                  empty,
  output logic                  aempty
);

  localparam int unsigned ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic                  mem_wr;
  logic [ADDR_WIDTH-1:0] mem_wr_addr;
  logic [ADDR_WIDTH:0]   wr_ptr_gray;
  logic [ADDR_WIDTH:0]   rd_ptr_bin_ws;

  logic                  mem_rd;
  logic [ADDR_WIDTH-1:0] mem_rd_addr;
  logic [ADDR_WIDTH:0]   rd_ptr_gray;
  logic [ADDR_WIDTH:0]   wr_ptr_bin_rs;

  dual_port_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_ram (
    .wr_clk   (wr_clk),
    .wr_en    (mem_wr),
    .wr_addr  (mem_wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (mem_rd),
    .rd_addr  (mem_rd_addr),
    .rd_data  (rd_data)
  );

  fifo_wr_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) i_wr_ctrl (
    .wr_clk        (wr_clk),
    .wr_rst_n      (wr_rst_n),
    .wr_en         (wr_en),
    .rd_ptr_bin_ws (rd_ptr_bin_ws),
    .mem_wr        (mem_wr),
    .mem_wr_addr   (mem_wr_addr),
    .wr_ptr_gray   (wr_ptr_gray),
    .full          (full),
    .afull         (afull)
  );

  fifo_rd_ctrl #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) i_rd_ctrl (
    .rd_clk        (rd_clk),
    .rd_rst_n      (rd_rst_n),
    .rd_en         (rd_en),
    .wr_ptr_bin_rs (wr_ptr_bin_rs),
    .mem_rd        (mem_rd),
    .mem_rd_addr   (mem_rd_addr),
    .rd_ptr_gray   (rd_ptr_gray),
    .empty         (empty),
    .aempty        (aempty)
  );

  // write pointer into read domain
  gray_sync #(.PTR_W(ADDR_WIDTH + 1)) i_wr2rd (
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .ptr_gray  (wr_ptr_gray),
    .ptr_bin   (wr_ptr_bin_rs)
  );

  // read pointer into write domain
  gray_sync #(.PTR_W(ADDR_WIDTH + 1)) i_rd2wr (
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .ptr_gray  (rd_ptr_gray),
    .ptr_bin   (rd_ptr_bin_ws)
  );

endmodule

`default_nettype wire

// File: tb/async_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_tb;

  localparam int unsigned DW    = 8;
  localparam int unsigned DEPTH = 16;

  localparam int OP_IDLE   = 0;
  localparam int OP_WRITE  = 1;
  localparam int OP_READ   = 2;
  localparam int OP_RANDOM = 3;

  localparam int NUM_ROWS      = 12;
  localparam int SETTLE_CYCLES = 10;   // wr_clk is the slower clock
  localparam int DRAIN_LIMIT   = 200;  // rd_clk cycles

  typedef struct {
    int   op;
    int   count;
    int   level;   // words expected in the FIFO after the row
    logic full;
    logic afull;
    logic empty;
    logic aempty;
  } row_t;

  logic          wr_clk;
  logic          wr_rst_n;
  logic          wr_en;
  logic [DW-1:0] wr_data;
  logic          rd_clk;
  logic          rd_rst_n;
  logic          rd_en;
  logic [DW-1:0] rd_data;
  logic          full;
  logic          afull;
  logic          empty;
  logic          aempty;

  logic [DW-1:0] model[$];
  logic [DW-1:0] exp_rd;   // value rd_data must hold
  row_t          rows [NUM_ROWS];
  integer        seed;

  async_fifo #(
    .DATA_WIDTH (DW),
    .FIFO_DEPTH (DEPTH)
  ) i_dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever #2 rd_clk = ~rd_clk;
  end

  // edges at 6k+3 never meet rd_clk edges at 4k+2
  initial begin
    wr_clk = 1'b0;
    forever #3 wr_clk = ~wr_clk;
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  function automatic row_t make_row(input int op, input int count, input int level,
                                    input logic f, input logic af,
                                    input logic e, input logic ae);
    row_t r;
    r.op     = op;
    r.count  = count;
    r.level  = level;
    r.full   = f;
    r.afull  = af;
    r.empty  = e;
    r.aempty = ae;
    return r;
  endfunction

  task automatic load_table;
    rows[0]  = make_row(OP_IDLE,     0,  0, 1'b0, 1'b0, 1'b1, 1'b1);  // after reset
    rows[1]  = make_row(OP_WRITE,    5,  5, 1'b0, 1'b0, 1'b0, 1'b0);
    rows[2]  = make_row(OP_READ,     5,  0, 1'b0, 1'b0, 1'b1, 1'b1);
    rows[3]  = make_row(OP_READ,     3,  0, 1'b0, 1'b0, 1'b1, 1'b1);  // reads on empty
    rows[4]  = make_row(OP_WRITE,    1,  1, 1'b0, 1'b0, 1'b0, 1'b1);
    rows[5]  = make_row(OP_WRITE,    1,  2, 1'b0, 1'b0, 1'b0, 1'b0);
    rows[6]  = make_row(OP_WRITE,   11, 13, 1'b0, 1'b0, 1'b0, 1'b0);
    rows[7]  = make_row(OP_WRITE,    1, 14, 1'b0, 1'b1, 1'b0, 1'b0);
    rows[8]  = make_row(OP_READ,    14,  0, 1'b0, 1'b0, 1'b1, 1'b1);
    rows[9]  = make_row(OP_WRITE,   18, 16, 1'b1, 1'b1, 1'b0, 1'b0);  // two dropped
    rows[10] = make_row(OP_READ,    16,  0, 1'b0, 1'b0, 1'b1, 1'b1);
    rows[11] = make_row(OP_RANDOM, 400,  0, 1'b0, 1'b0, 1'b1, 1'b1);  // then drained
  endtask

  // called right after a wr_clk edge, sees the values the DUT sampled
  task automatic accept_write;
    if (wr_en && !full) begin
      model.push_back(wr_data);
      assert (model.size() <= DEPTH)
        else stop_on_error($sformatf("FAILED at %0t: write accepted with %0d words held",
                                     $time, DEPTH));
    end
  endtask

  // called right after a rd_clk edge
  task automatic check_read;
    assert (rd_data === exp_rd)
      else stop_on_error($sformatf("FAILED at %0t: rd_data=%h, expected %h",
                                   $time, rd_data, exp_rd));
    if (rd_en && !empty) begin
      assert (model.size() > 0)
        else stop_on_error($sformatf("FAILED at %0t: read accepted with no word written",
                                     $time));
      exp_rd = model.pop_front();
    end
  endtask

  task automatic write_burst(input int count);
    logic [31:0] rnd;
    for (int n = 0; n < count; n++) begin
      @(posedge wr_clk);
      accept_write();
      rnd = $random(seed);
      wr_en   <= 1'b1;
      wr_data <= rnd[DW-1:0];
    end
    @(posedge wr_clk);
    accept_write();
    wr_en <= 1'b0;
  endtask

  task automatic read_tail;
    @(posedge rd_clk);
    check_read();
    rd_en <= 1'b0;
    @(posedge rd_clk);
    check_read();  // last word lands one edge later
  endtask

  task automatic read_burst(input int count);
    for (int n = 0; n < count; n++) begin
      @(posedge rd_clk);
      check_read();
      rd_en <= 1'b1;
    end
    read_tail();
  endtask

  task automatic random_traffic(input int cycles);
    logic [31:0] wr_rnd;
    logic [31:0] rd_rnd;
    fork
      begin
        for (int n = 0; n < cycles; n++) begin
          @(posedge wr_clk);
          accept_write();
          wr_rnd = $random(seed);
          wr_en   <= wr_rnd[DW];
          wr_data <= wr_rnd[DW-1:0];
        end
        @(posedge wr_clk);
        accept_write();
        wr_en <= 1'b0;
      end
      begin
        for (int n = 0; n < cycles; n++) begin
          @(posedge rd_clk);
          check_read();
          rd_rnd = $random(seed);
          rd_en <= rd_rnd[4];
        end
        read_tail();
      end
    join
  endtask

  task automatic drain_fifo;
    int cycles;
    cycles = 0;
    while (model.size() > 0 && cycles < DRAIN_LIMIT) begin
      @(posedge rd_clk);
      check_read();
      rd_en <= 1'b1;
      cycles++;
    end
    if (model.size() > 0) begin
      stop_on_error($sformatf("drain timed out after %0d read cycles with %0d words left",
                              DRAIN_LIMIT, model.size()));
    end
    read_tail();
  endtask

  task automatic settle;
    repeat (SETTLE_CYCLES) @(posedge wr_clk);
    @(negedge rd_clk);  // no rising edge of either clock here
  endtask

  task automatic check_flag(input string name, input logic got, input logic want,
                            input int row);
    assert (got === want)
      else stop_on_error($sformatf("FAILED at %0t: row %0d %s=%b, expected %b",
                                   $time, row, name, got, want));
  endtask

  task automatic check_row(input int i);
    check_flag("full", full, rows[i].full, i);
    check_flag("afull", afull, rows[i].afull, i);
    check_flag("empty", empty, rows[i].empty, i);
    check_flag("aempty", aempty, rows[i].aempty, i);
    assert (model.size() == rows[i].level)
      else stop_on_error($sformatf("FAILED at %0t: row %0d holds %0d words, expected %0d",
                                   $time, i, model.size(), rows[i].level));
  endtask

  initial begin
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    exp_rd   = '0;  // read register resets to zero
    seed     = 32'h6d3c5ac1;
    load_table();

    repeat (10) @(posedge rd_clk);
    wr_rst_n <= 1'b1;
    rd_rst_n <= 1'b1;

    for (int i = 0; i < NUM_ROWS; i++) begin
      case (rows[i].op)
        OP_WRITE: write_burst(rows[i].count);
        OP_READ:  read_burst(rows[i].count);
        OP_RANDOM: begin
          random_traffic(rows[i].count);
          settle();
          drain_fifo();
        end
        default: ;
      endcase
      settle();
      check_row(i);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rtl/afifo_pkg.sv
rtl/dual_port_ram.sv
rtl/gray_sync.sv
rtl/fifo_wr_ctrl.sv
rtl/fifo_rd_ctrl.sv
rtl/async_fifo.sv
tb/async_fifo_tb.sv

// File: Makefile
# Verilator build and run for the dual-clock FIFO testbench

SRCS := $(filter %.sv %.v,$(shell cat src.f))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vasync_fifo_tb: src.f $(SRCS)
	verilator --binary --timing --assert -f src.f \
	  --top-module async_fifo_tb -o Vasync_fifo_tb

sim.log: obj_dir/Vasync_fifo_tb
	./obj_dir/Vasync_fifo_tb | tee sim.log

run: obj_dir/Vasync_fifo_tb
	./obj_dir/Vasync_fifo_tb | tee sim.log
	@grep -q "All checks passed" sim.log && echo "run: PASS" || \
	  (echo "run: FAIL"; exit 1)

clean:
	rm -rf obj_dir sim.log
